/* design/dcache_pkg.sv */
// --------------------
// data cache port types
// request and response records of the cache load port
// --------------------
`include "load_unit_macros.svh"

package dcache_pkg;

    // access size as the cache sees it
    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD,
        SIZE_DOUBLE
    } xfer_size_e;

    // index phase fields go with data_req, the tag follows one cycle after the grant
    typedef struct packed {
        logic                     data_req;
        logic [`LU_INDEX_BITS-1:0] index;
        logic [`LU_TAG_BITS-1:0]   tag;
        logic                     tag_valid;
        logic [(`LU_XLEN/8)-1:0]   be;
        xfer_size_e               size;
    } dcache_req_t;

    // grant for the index phase and in-order read data
    typedef struct packed {
        logic                data_gnt;
        logic                data_rvalid;
        logic [`LU_XLEN-1:0] rdata;
    } dcache_rsp_t;

endpackage

/* design/load_issue_fsm.sv */
// --------------------
// load issue FSM
// checks the store hazard on the page offset, then sends the index
// phase and the tag phase of one load to the data cache
// --------------------
`timescale 1ns/1ps
`include "load_unit_macros.svh"

module load_issue_fsm (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      valid_i,
    input  load_pkg::load_req_t       load_req_i,
    output logic                      pop_ld_o,
    output logic [`LU_INDEX_BITS-1:0] page_offset_o,
    input  logic                      page_offset_matches_i,
    input  logic                      queue_full_i,
    input  logic                      dcache_gnt_i,
    output dcache_pkg::dcache_req_t   dcache_req_o,
    output logic                      meta_push_o,
    output load_pkg::load_meta_t      meta_o
);
    import load_pkg::*;
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_PAGE_OFFSET,
        WAIT_GNT,
        SEND_TAG
    } state_e;

    state_e state_d;
    state_e state_q;
    logic   data_req;
    logic   tag_valid;

    // map the operator to the access size the cache expects
    function automatic xfer_size_e size_of(input load_op_e op);
        xfer_size_e size;
        case (op)
            LW, LWU, FLW: size = SIZE_WORD;
            LH, LHU, FLH: size = SIZE_HALF;
            LB, LBU, FLB: size = SIZE_BYTE;
            default:      size = SIZE_DOUBLE;
        endcase
        return size;
    endfunction

    // the store hazard check only looks at the low 12 bits
    assign page_offset_o = load_req_i.addr[`LU_INDEX_BITS-1:0];

    // --------------------
    // cache request
    // --------------------
    // the request stays stable until pop_ld_o, so the tag can come straight from it
    assign dcache_req_o.data_req  = data_req;
    assign dcache_req_o.index     = load_req_i.addr[`LU_INDEX_BITS-1:0];
    assign dcache_req_o.tag       = load_req_i.addr[`LU_TAG_BITS+`LU_INDEX_BITS-1:`LU_INDEX_BITS];
    assign dcache_req_o.tag_valid = tag_valid;
    assign dcache_req_o.be        = load_req_i.be;
    assign dcache_req_o.size      = size_of(load_req_i.op);

    // the load leaves the queue in the tag cycle
    assign pop_ld_o = tag_valid;

    // metadata goes into the buffer in the grant cycle
    assign meta_o.trans_id = load_req_i.trans_id;
    assign meta_o.offset   = load_req_i.addr[`LU_OFFSET_BITS-1:0];
    assign meta_o.op       = load_req_i.op;

    // --------------------
    // state machine
    // --------------------
    always_comb begin
        state_d     = state_q;
        data_req    = 1'b0;
        tag_valid   = 1'b0;
        meta_push_o = 1'b0;
        case (state_q)
            IDLE: begin
                // a full buffer holds the new load back before anything is asked
                if (valid_i && !queue_full_i) begin
                    if (page_offset_matches_i) begin
                        // a pending store shares the offset so wait for it to drain
                        state_d = WAIT_PAGE_OFFSET;
                    end else begin
                        data_req = 1'b1;
                        if (dcache_gnt_i) begin
                            meta_push_o = 1'b1;
                            state_d     = SEND_TAG;
                        end else begin
                            state_d = WAIT_GNT;
                        end
                    end
                end
            end
            WAIT_PAGE_OFFSET: begin
                // the buffer cannot fill up while we sit here
                if (!page_offset_matches_i) begin
                    state_d = WAIT_GNT;
                end
            end
            WAIT_GNT: begin
                // keep asking until the cache takes the index
                data_req = 1'b1;
                if (dcache_gnt_i) begin
                    meta_push_o = 1'b1;
                    state_d     = SEND_TAG;
                end
            end
            SEND_TAG: begin
                // tag phase is a single cycle right after the grant
                tag_valid = 1'b1;
                state_d   = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

/* design/load_meta_queue.sv */
// --------------------
// load metadata FIFO
// keeps id, offset and operator of granted loads until their data returns
// --------------------
`timescale 1ns/1ps
`include "load_unit_macros.svh"

module load_meta_queue (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 push_i,
    input  load_pkg::load_meta_t meta_i,
    input  logic                 pop_i,
    output load_pkg::load_meta_t meta_o,
    output logic                 full_o
);
    import load_pkg::*;

    localparam int unsigned PTR_BITS = $clog2(`LU_QUEUE_DEPTH);
    localparam int unsigned CNT_BITS = $clog2(`LU_QUEUE_DEPTH + 1);

    load_meta_t          mem_q [`LU_QUEUE_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr_q;
    logic [PTR_BITS-1:0] rd_ptr_q;
    logic [CNT_BITS-1:0] count_q;
    logic                empty;
    logic                push_en;
    logic                pop_en;

    assign full_o = (count_q == CNT_BITS'(`LU_QUEUE_DEPTH));
    assign empty  = (count_q == '0);

    // a pop in the same cycle frees the slot a push would need
    assign push_en = push_i && (!full_o || pop_i);
    assign pop_en  = pop_i && !empty;

    // head is read without a register so the consumer sees it with rvalid
    assign meta_o = mem_q[rd_ptr_q];

    // --------------------
    // pointers and count
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_en) begin
                if (wr_ptr_q == PTR_BITS'(`LU_QUEUE_DEPTH - 1)) begin
                    wr_ptr_q <= '0;
                end else begin
                    wr_ptr_q <= wr_ptr_q + 1'b1;
                end
            end
            if (pop_en) begin
                if (rd_ptr_q == PTR_BITS'(`LU_QUEUE_DEPTH - 1)) begin
                    rd_ptr_q <= '0;
                end else begin
                    rd_ptr_q <= rd_ptr_q + 1'b1;
                end
            end
            // the count only moves when exactly one side acts
            if (push_en && !pop_en) begin
                count_q <= count_q + 1'b1;
            end else if (pop_en && !push_en) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // storage
    always_ff @(posedge clk_i) begin
        if (push_en) begin
            mem_q[wr_ptr_q] <= meta_i;
        end
    end

endmodule

/* design/load_pkg.sv */
// --------------------
// load unit types
// operator encoding and the request, metadata and result records
// --------------------
`include "load_unit_macros.svh"

package load_pkg;

    // load operators, the FP ones return NaN-boxed values
    typedef enum logic [3:0] {
        LD,
        LW,
        LWU,
        LH,
        LHU,
        LB,
        LBU,
        FLW,
        FLH,
        FLB
    } load_op_e;

    // one load as it comes from the load/store queue
    // the address is physical and covers index plus tag
    typedef struct packed {
        logic [`LU_TAG_BITS+`LU_INDEX_BITS-1:0] addr;
        load_op_e                               op;
        logic [(`LU_XLEN/8)-1:0]                be;
        logic [`LU_TRANS_ID_BITS-1:0]           trans_id;
    } load_req_t;

    // what the unit must remember about a load while the cache works on it
    typedef struct packed {
        logic [`LU_TRANS_ID_BITS-1:0] trans_id;
        logic [`LU_OFFSET_BITS-1:0]   offset;
        load_op_e                     op;
    } load_meta_t;

    // aligned and extended load data with the id of its load
    typedef struct packed {
        logic [`LU_TRANS_ID_BITS-1:0] trans_id;
        logic [`LU_XLEN-1:0]          data;
    } load_result_t;

endpackage

/* design/load_result_align.sv */
// --------------------
// load result alignment
// shifts the returned word by the byte offset and extends it
// by operator, then registers it with the transaction id
// --------------------
`timescale 1ns/1ps
`include "load_unit_macros.svh"

module load_result_align (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  dcache_pkg::dcache_rsp_t dcache_rsp_i,
    input  load_pkg::load_meta_t    meta_i,
    output logic                    pop_o,
    output logic                    valid_o,
    output load_pkg::load_result_t  result_o
);
    import load_pkg::*;

    logic [`LU_XLEN-1:0]        shifted_data;
    logic [(`LU_XLEN/8)-1:0]    sign_bits;
    logic [`LU_OFFSET_BITS-1:0] sign_idx;
    logic                       is_signed;
    logic                       is_fp;
    logic                       sign_bit;
    logic [`LU_XLEN-1:0]        ext_data;

    // every response belongs to the oldest load, so it retires the head entry
    assign pop_o = dcache_rsp_i.data_rvalid;

    // bring the addressed byte down to bit zero
    assign shifted_data = dcache_rsp_i.rdata >> {meta_i.offset, 3'b000};

    // --------------------
    // sign selection
    // --------------------
    // collect the top bit of each byte so the sign is picked in parallel to the shift
    for (genvar i = 0; i < (`LU_XLEN / 8); i++) begin : gen_sign_bits
        assign sign_bits[i] = dcache_rsp_i.rdata[(i+1)*8-1];
    end

    assign is_signed = meta_i.op inside {LW, LH, LB};
    assign is_fp     = meta_i.op inside {FLW, FLH, FLB};

    // index of the byte that holds the most significant bit of the field
    always_comb begin
        if (meta_i.op inside {LW, FLW}) begin
            sign_idx = meta_i.offset + `LU_OFFSET_BITS'(3);
        end else if (meta_i.op inside {LH, FLH}) begin
            sign_idx = meta_i.offset + `LU_OFFSET_BITS'(1);
        end else begin
            sign_idx = meta_i.offset;
        end
    end

    // unsigned loads fill with zero, FP loads are NaN-boxed with ones
    assign sign_bit = (is_signed & sign_bits[sign_idx]) | is_fp;

    // --------------------
    // extension
    // --------------------
    always_comb begin
        case (meta_i.op)
            LW, LWU, FLW: ext_data = {{(`LU_XLEN-32){sign_bit}}, shifted_data[31:0]};
            LH, LHU, FLH: ext_data = {{(`LU_XLEN-16){sign_bit}}, shifted_data[15:0]};
            LB, LBU, FLB: ext_data = {{(`LU_XLEN-8){sign_bit}}, shifted_data[7:0]};
            default:      ext_data = shifted_data;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= dcache_rsp_i.data_rvalid;
        end
    end

    // result only changes when the cache answers
    always_ff @(posedge clk_i) begin
        if (dcache_rsp_i.data_rvalid) begin
            result_o.trans_id <= meta_i.trans_id;
            result_o.data     <= ext_data;
        end
    end

endmodule

/* design/load_unit.sv */
// --------------------
// load unit
// issue FSM, metadata FIFO and result alignment for in-order cache loads
// --------------------
`timescale 1ns/1ps
`include "load_unit_macros.svh"

module load_unit (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      valid_i,
    input  load_pkg::load_req_t       load_req_i,
    output logic                      pop_ld_o,
    output logic [`LU_INDEX_BITS-1:0] page_offset_o,
    input  logic                      page_offset_matches_i,
    output dcache_pkg::dcache_req_t   dcache_req_o,
    input  dcache_pkg::dcache_rsp_t   dcache_rsp_i,
    output logic                      valid_o,
    output load_pkg::load_result_t    result_o
);
    import load_pkg::*;

    logic       meta_push;
    logic       meta_pop;
    logic       queue_full;
    load_meta_t meta_in;
    load_meta_t meta_head;

    // producer side
    load_issue_fsm i_issue (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .valid_i               (valid_i),
        .load_req_i            (load_req_i),
        .pop_ld_o              (pop_ld_o),
        .page_offset_o         (page_offset_o),
        .page_offset_matches_i (page_offset_matches_i),
        .queue_full_i          (queue_full),
        .dcache_gnt_i          (dcache_rsp_i.data_gnt),
        .dcache_req_o          (dcache_req_o),
        .meta_push_o           (meta_push),
        .meta_o                (meta_in)
    );

    // loads in flight between grant and response
    load_meta_queue i_queue (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .push_i (meta_push),
        .meta_i (meta_in),
        .pop_i  (meta_pop),
        .meta_o (meta_head),
        .full_o (queue_full)
    );

    // consumer side
    load_result_align i_align (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .dcache_rsp_i (dcache_rsp_i),
        .meta_i       (meta_head),
        .pop_o        (meta_pop),
        .valid_o      (valid_o),
        .result_o     (result_o)
    );

endmodule

/* design/load_unit_macros.svh */
// --------------------
// load unit parameters
// shared widths and depths for the load unit and its cache port
// --------------------
`ifndef LOAD_UNIT_MACROS_SVH
`define LOAD_UNIT_MACROS_SVH

// width of a data word and of the load result
`define LU_XLEN 64

// width of the transaction id handed back with every result
`define LU_TRANS_ID_BITS 3

// cache index bits, equal to the page offset so no translation is needed for it
`define LU_INDEX_BITS 12

// cache tag bits taken from the address above the index
`define LU_TAG_BITS 44

// loads that may be granted and still waiting for their data
`define LU_QUEUE_DEPTH 4

// byte offset inside one data word
`define LU_OFFSET_BITS 3

`endif

/* sim.f */
+incdir+design
design/load_pkg.sv
design/dcache_pkg.sv
design/load_issue_fsm.sv
design/load_meta_queue.sv
design/load_result_align.sv
design/load_unit.sv
testbench/dcache_model.sv
testbench/tb_load_unit.sv

/* testbench/dcache_model.sv */
// --------------------
// data cache model
// grants with random back-pressure, answers granted loads in order
// after random delays and opens random store hazard windows
// --------------------
`timescale 1ns/1ps
`include "load_unit_macros.svh"

module dcache_model #(
    parameter logic [31:0] SEED = 32'd1
) (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  dcache_pkg::dcache_req_t dcache_req_i,
    output dcache_pkg::dcache_rsp_t dcache_rsp_o,
    output logic                    page_offset_matches_o
);
    import dcache_pkg::*;

    logic [31:0]               rng_state = SEED;
    logic [`LU_INDEX_BITS-1:0] pend_index[$];
    int                        pend_delay[$];
    int                        req_wait = 0;
    int                        hazard_left = 0;

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> 16;
    endfunction

    // byte k of the word at an index is the low index byte mixed with k
    function automatic logic [`LU_XLEN-1:0] word_at(input logic [`LU_INDEX_BITS-1:0] index);
        logic [`LU_XLEN-1:0] word;
        for (int k = 0; k < `LU_XLEN / 8; k++) begin
            word[k*8 +: 8] = index[7:0] ^ 8'(k) ^ 8'hA5;
        end
        return word;
    endfunction

    initial begin
        dcache_rsp_o          = '0;
        page_offset_matches_o = 1'b0;
    end

    // the request side is looked at just before the edge
    always @(posedge clk_i) begin
        if (dcache_req_i.data_req && dcache_rsp_o.data_gnt) begin
            pend_index.push_back(dcache_req_i.index);
            pend_delay.push_back(1 + int'(lcg_next() % 6));
            req_wait = 0;
        end else if (dcache_req_i.data_req) begin
            req_wait++;
        end
    end

    // --------------------
    // outputs for the next cycle
    // --------------------
    always @(negedge clk_i) begin
        dcache_rsp_o.data_rvalid = 1'b0;
        if (!rst_ni) begin
            dcache_rsp_o.data_gnt = 1'b0;
            page_offset_matches_o = 1'b0;
        end else begin
            // a request never waits more than three cycles for its grant
            dcache_rsp_o.data_gnt = (req_wait >= 3) || (lcg_next() % 2 == 0);
            // only the oldest load counts down, so data returns in grant order
            if (pend_index.size() > 0) begin
                if (pend_delay[0] <= 1) begin
                    dcache_rsp_o.data_rvalid = 1'b1;
                    dcache_rsp_o.rdata       = word_at(pend_index.pop_front());
                    void'(pend_delay.pop_front());
                end else begin
                    pend_delay[0] = pend_delay[0] - 1;
                end
            end
            // a pending store to the same offset holds for up to five cycles
            if (hazard_left > 0) begin
                page_offset_matches_o = 1'b1;
                hazard_left--;
            end else begin
                page_offset_matches_o = 1'b0;
                if (lcg_next() % 4 == 0) begin
                    hazard_left = int'(lcg_next() % 6);
                end
            end
        end
    end

endmodule

/* testbench/tb_load_unit.sv */
// --------------------
// load unit testbench
// random loads against the cache model, checked by assertions
// --------------------
`timescale 1ns/1ps
`include "load_unit_macros.svh"

module tb_load_unit;
    import load_pkg::*;
    import dcache_pkg::*;

    localparam int N_LOADS    = 200;
    localparam int CLK_PERIOD = 20;

    logic                    clk_i;
    logic                    rst_ni;
    logic                    valid;
    load_req_t               load_req;
    logic                    pop_ld;
    logic [`LU_INDEX_BITS-1:0] page_offset;
    logic                    offset_match;
    dcache_req_t             dcache_req;
    dcache_rsp_t             dcache_rsp;
    logic                    result_valid;
    load_result_t            result;

    logic [31:0]             rng_state = 32'd77344;
    load_result_t            exp_q[$];
    int                      results_seen = 0;
    int                      outstanding = 0;
    logic                    prev_grant = 1'b0;
    logic                    prev_req = 1'b0;
    logic                    prev_match = 1'b0;
    logic [`LU_TAG_BITS-1:0] cur_tag = '0;

    load_unit DUT (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .valid_i               (valid),
        .load_req_i            (load_req),
        .pop_ld_o              (pop_ld),
        .page_offset_o         (page_offset),
        .page_offset_matches_i (offset_match),
        .dcache_req_o          (dcache_req),
        .dcache_rsp_i          (dcache_rsp),
        .valid_o               (result_valid),
        .result_o              (result)
    );

    dcache_model #(.SEED(32'd77344)) i_cache (
        .clk_i                 (clk_i),
        .rst_ni                (rst_ni),
        .dcache_req_i          (dcache_req),
        .dcache_rsp_o          (dcache_rsp),
        .page_offset_matches_o (offset_match)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state >> 16;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        abort_run($sformatf("Fail at %0t: %s expected %0h, got %0h",
                            $time, name, expected, actual));
    endtask

    function automatic int op_bytes(input load_op_e op);
        case (op)
            LD:           return 8;
            LW, LWU, FLW: return 4;
            LH, LHU, FLH: return 2;
            default:      return 1;
        endcase
    endfunction

    // gather the field byte by byte from the data rule, then fill above it
    function automatic logic [`LU_XLEN-1:0] expected_data(input load_op_e op,
                                                          input logic [`LU_INDEX_BITS-1:0] idx);
        logic [`LU_XLEN-1:0] value;
        logic                fill;
        int                  nbytes;
        nbytes = op_bytes(op);
        value  = '0;
        for (int k = 0; k < nbytes; k++) begin
            value[k*8 +: 8] = idx[7:0] ^ 8'(int'(idx[2:0]) + k) ^ 8'hA5;
        end
        fill = (op inside {FLW, FLH, FLB}) || ((op inside {LW, LH, LB}) && value[nbytes*8-1]);
        for (int j = nbytes * 8; j < `LU_XLEN; j++) begin
            value[j] = fill;
        end
        return value;
    endfunction

    // --------------------
    // checks on the cycle that ends at this edge
    // --------------------
    always @(posedge clk_i) begin
        if (rst_ni) begin
            // the tag phase and the pop both belong to the cycle after a grant
            assert (dcache_req.tag_valid == prev_grant)
                else report_mismatch("tag_valid", prev_grant, dcache_req.tag_valid);
            assert (pop_ld == prev_grant)
                else report_mismatch("pop_ld_o", prev_grant, pop_ld);
            if (dcache_req.tag_valid) begin
                assert (dcache_req.tag == cur_tag)
                    else report_mismatch("tag", cur_tag, dcache_req.tag);
            end
            // the offset seen by the store check is the low part of the request address
            assert (page_offset == load_req.addr[`LU_INDEX_BITS-1:0])
                else report_mismatch("page_offset_o", load_req.addr[`LU_INDEX_BITS-1:0],
                                     page_offset);
            // the index phase carries the offset, enables and size of the current load
            if (dcache_req.data_req) begin
                assert (dcache_req.index == load_req.addr[`LU_INDEX_BITS-1:0])
                    else report_mismatch("index", load_req.addr[`LU_INDEX_BITS-1:0],
                                         dcache_req.index);
                assert (dcache_req.be == load_req.be)
                    else report_mismatch("be", load_req.be, dcache_req.be);
                // the size code is log2 of the access width in bytes
                assert (dcache_req.size == xfer_size_e'($clog2(op_bytes(load_req.op))))
                    else report_mismatch("size", $clog2(op_bytes(load_req.op)),
                                         dcache_req.size);
            end
            // a new request needs the hazard seen clear this cycle or the one before
            if (dcache_req.data_req && !prev_req) begin
                assert (!offset_match || !prev_match)
                    else abort_run("data_req rose while a store hazard was pending");
            end
            assert (!(outstanding == `LU_QUEUE_DEPTH && dcache_req.data_req))
                else abort_run("data_req raised while four loads were outstanding");
            if (result_valid) begin
                assert (exp_q.size() > 0) else abort_run("result seen with no load pending");
                assert (result.trans_id == exp_q[0].trans_id)
                    else report_mismatch("result_o.trans_id", exp_q[0].trans_id, result.trans_id);
                assert (result.data == exp_q[0].data)
                    else report_mismatch("result_o.data", exp_q[0].data, result.data);
                void'(exp_q.pop_front());
                results_seen++;
            end
            outstanding = outstanding + int'(dcache_req.data_req && dcache_rsp.data_gnt)
                          - int'(dcache_rsp.data_rvalid);
            prev_grant  = dcache_req.data_req && dcache_rsp.data_gnt;
            prev_req    = dcache_req.data_req;
            prev_match  = offset_match;
        end
    end

    // --------------------
    // stimulus
    // --------------------
    initial begin
        load_op_e                  op;
        logic [`LU_INDEX_BITS-1:0] idx;
        load_result_t              exp;
        int                        slot;
        int                        nbytes;
        rst_ni   = 1'b0;
        valid    = 1'b0;
        load_req = '0;
        repeat (3) @(negedge clk_i);
        rst_ni = 1'b1;
        assert (!dcache_req.data_req) else report_mismatch("data_req", 0, dcache_req.data_req);
        assert (!dcache_req.tag_valid) else report_mismatch("tag_valid", 0, dcache_req.tag_valid);
        assert (!pop_ld) else report_mismatch("pop_ld_o", 0, pop_ld);
        assert (!result_valid) else report_mismatch("valid_o", 0, result_valid);
        for (int i = 0; i < N_LOADS; i++) begin
            // the first 80 loads sweep every operator over every aligned offset
            if (i < 80) begin
                op   = load_op_e'(i % 10);
                slot = i / 10;
            end else begin
                op   = load_op_e'(lcg_next() % 10);
                slot = int'(lcg_next() % 8);
            end
            nbytes          = op_bytes(op);
            idx             = {9'(lcg_next()), 3'((slot * nbytes) % 8)};
            cur_tag[43:32]  = 12'(lcg_next());
            cur_tag[31:16]  = 16'(lcg_next());
            cur_tag[15:0]   = 16'(lcg_next());
            if (lcg_next() % 8 == 0) begin
                valid = 1'b0;
                @(negedge clk_i);
            end
            load_req.addr     = {cur_tag, idx};
            load_req.op       = op;
            load_req.be       = 8'(((1 << nbytes) - 1) << idx[2:0]);
            load_req.trans_id = `LU_TRANS_ID_BITS'(i);
            valid             = 1'b1;
            exp.trans_id      = `LU_TRANS_ID_BITS'(i);
            exp.data          = expected_data(op, idx);
            exp_q.push_back(exp);
            // the request is taken at the edge that ends the pop cycle
            do @(negedge clk_i); while (!pop_ld);
            @(negedge clk_i);
        end
        valid = 1'b0;
        wait (results_seen == N_LOADS);
        @(negedge clk_i);
        // every grant must have been answered once the last result is out
        if (outstanding == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_run("granted loads were left without a result at the end of the run");
        end
    end

    // every load gets twenty cycles, plus some slack for reset
    initial begin
        #((N_LOADS * 20 + 10) * CLK_PERIOD);
        abort_run($sformatf("timeout with %0d of %0d results seen", results_seen, N_LOADS));
    end

endmodule
